//--- include/ex_settings.svh
/*
  Execute stage settings
*/
`ifndef EX_SETTINGS_SVH
`define EX_SETTINGS_SVH

// Data path width
`define EX_XLEN 32

// Register file address width
`define EX_RADDR_W 6

// Redundant ALU replicas
`define EX_LANES 3

// Per-lane disagreement counter
`define EX_FCNT_W 8

// Count at which a lane is taken out of the vote
`define EX_FAULT_THRESHOLD 4

// Counter select on the access port
`define EX_CNT_ADDR_W 2

`endif

//--- source/ex_pkg.sv
/*
  Execute stage types
*/
`include "ex_settings.svh"

package ex_pkg;

  // ALU operations
  // Compare ops also give the branch condition
  typedef enum logic [3:0] {
    ADD, SUB, AND, OR, XOR,
    SLL, SRL, SRA,
    SLT, SLTU,
    EQ, NE, LT, GE
  } alu_op_e;

  // Multiplier operations
  typedef enum logic [1:0] {
    MUL, MULH, MULHSU, MULHU
  } mult_op_e;

  // High-word product sequencing
  typedef enum logic [1:0] {
    IDLE, HIGH_STEP, DONE
  } mult_state_e;

  // One lane's copy of the ALU request
  typedef struct packed {
    alu_op_e                operator;
    logic [`EX_XLEN-1:0]    operand_a;
    logic [`EX_XLEN-1:0]    operand_b;
  } alu_req_t;

  typedef struct packed {
    mult_op_e               operator;
    logic [`EX_XLEN-1:0]    operand_a;
    logic [`EX_XLEN-1:0]    operand_b;
  } mult_req_t;

  // Voted control from decode
  typedef struct packed {
    logic                   alu_en;
    logic                   mult_en;
    logic                   csr_access;
    logic                   lsu_en;
    logic                   branch_in_ex;
    logic                   regfile_alu_we;
    logic [`EX_RADDR_W-1:0] regfile_alu_waddr;
    logic                   regfile_we;
    logic [`EX_RADDR_W-1:0] regfile_waddr;
    logic [`EX_XLEN-1:0]    jump_target;
  } ex_ctrl_t;

  // Register file write port
  typedef struct packed {
    logic                   we;
    logic [`EX_RADDR_W-1:0] waddr;
    logic [`EX_XLEN-1:0]    wdata;
  } rf_write_t;

  typedef struct packed {
    logic                   err_corrected;
    logic                   err_detected;
    logic [`EX_LANES-1:0]   faulty;
  } tmr_status_t;

endpackage

//--- source/alu_lane.sv
/*
  ALU replica
*/
`include "ex_settings.svh"

module alu_lane (
  input  ex_pkg::alu_req_t    req_i,
  output logic [`EX_XLEN-1:0] result_o,
  output logic                cmp_o
);

  localparam int SHAMT_W = $clog2(`EX_XLEN);

  logic                sub;
  logic [`EX_XLEN-1:0] b_mux;
  logic [`EX_XLEN:0]   adder;
  logic [SHAMT_W-1:0]  shamt;
  logic                eq;
  logic                lt_s;
  logic                lt_u;

  // Single adder shared by add, sub and all compares
  assign sub   = (req_i.operator != ex_pkg::ADD);
  assign b_mux = sub ? ~req_i.operand_b : req_i.operand_b;
  assign adder = {1'b0, req_i.operand_a} + {1'b0, b_mux} + {{`EX_XLEN{1'b0}}, sub};

  assign shamt = req_i.operand_b[SHAMT_W-1:0];

  // No carry out of a - b means a < b unsigned
  assign eq   = (req_i.operand_a == req_i.operand_b);
  assign lt_u = ~adder[`EX_XLEN];
  // Sign bits differ so a is smaller when it is negative
  assign lt_s = (req_i.operand_a[`EX_XLEN-1] != req_i.operand_b[`EX_XLEN-1]) ?
                req_i.operand_a[`EX_XLEN-1] : adder[`EX_XLEN-1];

  // Comparison bit for branches and set-less-than
  always_comb begin
    unique case (req_i.operator)
      ex_pkg::EQ:              cmp_o = eq;
      ex_pkg::NE:              cmp_o = ~eq;
      ex_pkg::LT, ex_pkg::SLT: cmp_o = lt_s;
      ex_pkg::GE:              cmp_o = ~lt_s;
      ex_pkg::SLTU:            cmp_o = lt_u;
      default:                 cmp_o = 1'b0;
    endcase
  end

  always_comb begin
    unique case (req_i.operator)
      ex_pkg::ADD, ex_pkg::SUB: result_o = adder[`EX_XLEN-1:0];
      ex_pkg::AND:              result_o = req_i.operand_a & req_i.operand_b;
      ex_pkg::OR:               result_o = req_i.operand_a | req_i.operand_b;
      ex_pkg::XOR:              result_o = req_i.operand_a ^ req_i.operand_b;
      ex_pkg::SLL:              result_o = req_i.operand_a << shamt;
      ex_pkg::SRL:              result_o = req_i.operand_a >> shamt;
      ex_pkg::SRA:              result_o = $signed(req_i.operand_a) >>> shamt;
      // Set and branch compares return the bit zero extended
      default:                  result_o = {{(`EX_XLEN-1){1'b0}}, cmp_o};
    endcase
  end

endmodule

//--- source/tmr_voter.sv
/*
  TMR majority voter
*/
`include "ex_settings.svh"

module tmr_voter (
  input  logic [`EX_LANES-1:0][`EX_XLEN-1:0] result_i,
  input  logic [`EX_LANES-1:0]               cmp_i,
  input  logic                               alu_en_i,
  input  logic [`EX_LANES-1:0]               faulty_i,
  output logic [`EX_XLEN-1:0]                result_o,
  output logic                               cmp_o,
  output logic [`EX_LANES-1:0]               mismatch_o,
  output ex_pkg::tmr_status_t                status_o
);

  localparam int LANE_W = $clog2(`EX_LANES);

  logic [`EX_XLEN-1:0]  maj_result;
  logic                 maj_cmp;
  logic [`EX_LANES-1:0] bad;
  logic [LANE_W-1:0]    lane_a;
  logic [LANE_W-1:0]    lane_b;
  logic                 pair_mode;

  // Bitwise majority over three lanes
  assign maj_result = (result_i[0] & result_i[1]) | (result_i[0] & result_i[2]) |
                      (result_i[1] & result_i[2]);
  assign maj_cmp    = (cmp_i[0] & cmp_i[1]) | (cmp_i[0] & cmp_i[2]) | (cmp_i[1] & cmp_i[2]);

  always_comb begin
    for (int i = 0; i < `EX_LANES; i++) begin
      bad[i] = (result_i[i] != maj_result) | (cmp_i[i] != maj_cmp);
    end
  end

  // Healthy lanes left over when one lane is out
  always_comb begin
    pair_mode = 1'b1;
    lane_a    = '0;
    lane_b    = LANE_W'(1);
    unique case (faulty_i)
      3'b001:  begin lane_a = LANE_W'(1); lane_b = LANE_W'(2); end
      3'b010:  lane_b = LANE_W'(2);
      3'b100:  lane_b = LANE_W'(1);
      default: pair_mode = 1'b0;
    endcase
  end

  always_comb begin
    result_o   = maj_result;
    cmp_o      = maj_cmp;
    mismatch_o = '0;
    status_o   = '0;
    if (faulty_i == '0) begin
      // One lane outvoted gets counted
      if ($onehot(bad)) begin
        status_o.err_corrected = alu_en_i;
        mismatch_o             = bad & {`EX_LANES{alu_en_i}};
      end else if (|bad) begin
        status_o.err_detected = alu_en_i;
      end
    end else if (pair_mode) begin
      // Two lanes left so only detection is possible
      result_o = result_i[lane_a];
      cmp_o    = cmp_i[lane_a];
      if ((result_i[lane_a] != result_i[lane_b]) || (cmp_i[lane_a] != cmp_i[lane_b])) begin
        status_o.err_detected = alu_en_i;
      end
    end else begin
      // Down to a single lane
      for (int i = `EX_LANES-1; i >= 0; i--) begin
        if (!faulty_i[i]) begin
          result_o = result_i[i];
          cmp_o    = cmp_i[i];
        end
      end
    end
  end

endmodule

//--- source/fault_counter.sv
/*
  Lane fault counters
*/
`include "ex_settings.svh"

module fault_counter (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [`EX_LANES-1:0]      mismatch_i,
  input  logic [`EX_CNT_ADDR_W-1:0] cnt_addr_i,
  input  logic                      cnt_we_i,
  input  logic [`EX_FCNT_W-1:0]     cnt_wdata_i,
  output logic [`EX_FCNT_W-1:0]     cnt_rdata_o,
  output logic [`EX_LANES-1:0]      faulty_o
);

  logic [`EX_LANES-1:0][`EX_FCNT_W-1:0] cnt_q;

  for (genvar g = 0; g < `EX_LANES; g++) begin : g_lane

    logic sel;
    logic sat;

    assign sel = cnt_we_i && (cnt_addr_i == `EX_CNT_ADDR_W'(g));
    // Stop at all ones instead of wrapping back to zero
    assign sat = &cnt_q[g];

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        cnt_q[g] <= '0;
      end else if (sel) begin
        // Software write wins over a mismatch in the same cycle
        cnt_q[g] <= cnt_wdata_i;
      end else if (mismatch_i[g] && !sat) begin
        cnt_q[g] <= cnt_q[g] + 1'b1;
      end
    end

    // Lane out of the vote while at or over threshold
    // Writing a lower count brings it back
    assign faulty_o[g] = (cnt_q[g] >= `EX_FCNT_W'(`EX_FAULT_THRESHOLD));

  end

  // Unused selects read as zero
  assign cnt_rdata_o = (cnt_addr_i < `EX_LANES) ? cnt_q[cnt_addr_i] : '0;

endmodule

//--- source/mult_ctrl.sv
/*
  Multiplier control FSM
*/
`include "ex_settings.svh"

module mult_ctrl (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             en_i,
  input  ex_pkg::mult_op_e op_i,
  input  logic             ex_ready_i,
  output logic             low_step_o,
  output logic             high_step_o,
  output logic             result_valid_o,
  output logic             ready_o,
  output logic             multicycle_o
);

  ex_pkg::mult_state_e state_q;
  ex_pkg::mult_state_e state_d;
  logic                high_op;

  // MULH variants need the extra partial product step
  assign high_op = en_i && (op_i != ex_pkg::MUL);

  always_comb begin
    state_d        = state_q;
    low_step_o     = 1'b0;
    high_step_o    = 1'b0;
    result_valid_o = 1'b0;
    ready_o        = 1'b1;
    multicycle_o   = 1'b0;
    unique case (state_q)
      ex_pkg::IDLE: begin
        if (high_op) begin
          low_step_o   = 1'b1;
          ready_o      = 1'b0;
          multicycle_o = 1'b1;
          state_d      = ex_pkg::HIGH_STEP;
        end else begin
          // Plain MUL finishes in the request cycle
          result_valid_o = en_i;
        end
      end
      ex_pkg::HIGH_STEP: begin
        high_step_o  = 1'b1;
        ready_o      = 1'b0;
        multicycle_o = 1'b1;
        state_d      = ex_pkg::DONE;
      end
      ex_pkg::DONE: begin
        // Hold the upper word until write-back takes it
        result_valid_o = 1'b1;
        if (ex_ready_i) state_d = ex_pkg::IDLE;
      end
      default: state_d = ex_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) state_q <= ex_pkg::IDLE;
    else        state_q <= state_d;
  end

endmodule

//--- source/mult_datapath.sv
/*
  Multiplier datapath
*/
`include "ex_settings.svh"

module mult_datapath (
  input  logic                clk,
  input  logic                rst_n,
  input  ex_pkg::mult_req_t   req_i,
  input  logic                low_step_i,
  input  logic                high_step_i,
  output logic [`EX_XLEN-1:0] result_o
);

  localparam int XL   = `EX_XLEN;
  localparam int HALF = XL / 2;
  localparam int PW   = XL + HALF + 2;
  localparam int FW   = 2 * XL;

  logic               sign_a;
  logic               sign_b;
  logic signed [XL:0]   a_ext;
  logic signed [HALF:0] b_lo;
  logic signed [HALF:0] b_hi;
  logic signed [PW-1:0] prod_lo;
  logic signed [PW-1:0] prod_hi;
  logic [XL-1:0]        mul_lo;
  logic [FW-1:0]        partial_q;
  logic [FW-1:0]        acc_q;

  // MULH signs both operands and MULHSU only a
  assign sign_a = (req_i.operator == ex_pkg::MULH) || (req_i.operator == ex_pkg::MULHSU);
  assign sign_b = (req_i.operator == ex_pkg::MULH);

  assign a_ext = $signed({sign_a & req_i.operand_a[XL-1], req_i.operand_a});
  // Low half is always unsigned and the high half carries the sign
  assign b_lo  = $signed({1'b0, req_i.operand_b[HALF-1:0]});
  assign b_hi  = $signed({sign_b & req_i.operand_b[XL-1], req_i.operand_b[XL-1:HALF]});

  assign prod_lo = a_ext * b_lo;
  assign prod_hi = a_ext * b_hi;

  // Low word for MUL in one cycle
  assign mul_lo = req_i.operand_a * req_i.operand_b;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      partial_q <= '0;
      acc_q     <= '0;
    end else begin
      if (low_step_i)  partial_q <= FW'(prod_lo);
      // Shifted high partial on top of the stored low partial
      if (high_step_i) acc_q <= partial_q + (FW'(prod_hi) << HALF);
    end
  end

  assign result_o = (req_i.operator == ex_pkg::MUL) ? mul_lo : acc_q[FW-1:XL];

endmodule

//--- source/ex_stage.sv
/*
  Fault-tolerant execute stage
*/
`include "ex_settings.svh"

module ex_stage (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  ex_pkg::alu_req_t [`EX_LANES-1:0]      alu_req_i,
  input  ex_pkg::mult_req_t                     mult_req_i,
  input  ex_pkg::ex_ctrl_t                      ex_ctrl_i,
  input  logic [`EX_XLEN-1:0]                   csr_rdata_i,
  input  logic [`EX_XLEN-1:0]                   lsu_rdata_i,
  input  logic                                  lsu_ready_i,
  input  logic                                  lsu_err_i,
  input  logic                                  wb_ready_i,
  input  logic [`EX_CNT_ADDR_W-1:0]             cnt_addr_i,
  input  logic                                  cnt_we_i,
  input  logic [`EX_FCNT_W-1:0]                 cnt_wdata_i,
  output ex_pkg::rf_write_t                     fw_o,
  output ex_pkg::rf_write_t                     wb_o,
  output logic                                  branch_decision_o,
  output logic [`EX_XLEN-1:0]                   jump_target_o,
  output logic                                  ex_ready_o,
  output logic                                  ex_valid_o,
  output logic                                  mult_multicycle_o,
  output ex_pkg::tmr_status_t                   tmr_status_o,
  output logic [`EX_FCNT_W-1:0]                 cnt_rdata_o
);

  logic [`EX_LANES-1:0][`EX_XLEN-1:0] lane_result;
  logic [`EX_LANES-1:0]               lane_cmp;
  logic [`EX_LANES-1:0]               mismatch;
  logic [`EX_LANES-1:0]               faulty;
  logic [`EX_XLEN-1:0]                alu_result;
  logic                               alu_cmp;
  logic                               vote_en;
  ex_pkg::tmr_status_t                voter_status;
  logic                               mult_low_step;
  logic                               mult_high_step;
  logic                               mult_result_valid;
  logic                               mult_ready;
  logic [`EX_XLEN-1:0]                mult_result;
  logic                               stage_ready;
  logic                               wb_we_q;
  logic [`EX_RADDR_W-1:0]             wb_waddr_q;

  //////////////////////////////////////////////////////////
  // Redundant ALU lanes and vote
  //////////////////////////////////////////////////////////

  for (genvar g = 0; g < `EX_LANES; g++) begin : g_alu
    alu_lane u_alu_lane (
      .req_i    (alu_req_i[g]),
      .result_o (lane_result[g]),
      .cmp_o    (lane_cmp[g])
    );
  end

  // Count each ALU op once and not on every stalled cycle
  assign vote_en = ex_ctrl_i.alu_en & ex_valid_o;

  tmr_voter u_tmr_voter (
    .result_i   (lane_result),
    .cmp_i      (lane_cmp),
    .alu_en_i   (vote_en),
    .faulty_i   (faulty),
    .result_o   (alu_result),
    .cmp_o      (alu_cmp),
    .mismatch_o (mismatch),
    .status_o   (voter_status)
  );

  fault_counter u_fault_counter (
    .clk         (clk),
    .rst_n       (rst_n),
    .mismatch_i  (mismatch),
    .cnt_addr_i  (cnt_addr_i),
    .cnt_we_i    (cnt_we_i),
    .cnt_wdata_i (cnt_wdata_i),
    .cnt_rdata_o (cnt_rdata_o),
    .faulty_o    (faulty)
  );

  // Faulty lanes come from the counters
  always_comb begin
    tmr_status_o        = voter_status;
    tmr_status_o.faulty = faulty;
  end

  //////////////////////////////////////////////////////////
  // Multiplier
  //////////////////////////////////////////////////////////

  mult_ctrl u_mult_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .en_i           (ex_ctrl_i.mult_en),
    .op_i           (mult_req_i.operator),
    .ex_ready_i     (ex_ready_o),
    .low_step_o     (mult_low_step),
    .high_step_o    (mult_high_step),
    .result_valid_o (mult_result_valid),
    .ready_o        (mult_ready),
    .multicycle_o   (mult_multicycle_o)
  );

  mult_datapath u_mult_datapath (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_i       (mult_req_i),
    .low_step_i  (mult_low_step),
    .high_step_i (mult_high_step),
    .result_o    (mult_result)
  );

  //////////////////////////////////////////////////////////
  // Write ports and handshake
  //////////////////////////////////////////////////////////

  // Forwarding port priority is CSR then multiplier then ALU
  always_comb begin
    fw_o.we    = ex_ctrl_i.regfile_alu_we;
    fw_o.waddr = ex_ctrl_i.regfile_alu_waddr;
    fw_o.wdata = '0;
    if (ex_ctrl_i.alu_en)                         fw_o.wdata = alu_result;
    if (ex_ctrl_i.mult_en && mult_result_valid)   fw_o.wdata = mult_result;
    if (ex_ctrl_i.csr_access)                     fw_o.wdata = csr_rdata_i;
  end

  // EX/WB register for the load write-back
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_we_q    <= 1'b0;
      wb_waddr_q <= '0;
    end else if (ex_valid_o) begin
      // A faulting load never writes
      wb_we_q    <= ex_ctrl_i.regfile_we & ~lsu_err_i;
      wb_waddr_q <= ex_ctrl_i.regfile_waddr;
    end else if (wb_ready_i) begin
      // Bubble into write-back
      wb_we_q <= 1'b0;
    end
  end

  // Load data arrives with the registered address
  assign wb_o = '{we: wb_we_q, waddr: wb_waddr_q, wdata: lsu_rdata_i};

  assign branch_decision_o = alu_cmp;
  assign jump_target_o     = ex_ctrl_i.jump_target;

  // Branches resolve here without needing write-back
  assign stage_ready = mult_ready & lsu_ready_i & wb_ready_i;
  assign ex_ready_o  = stage_ready | ex_ctrl_i.branch_in_ex;
  assign ex_valid_o  = (ex_ctrl_i.alu_en | ex_ctrl_i.mult_en | ex_ctrl_i.csr_access |
                        ex_ctrl_i.lsu_en) & stage_ready;

endmodule

//--- tb/ex_stage_checker.sv
/*
  Execute stage assertions
*/

module ex_stage_checker (
  input logic              clk,
  input logic              rst_n,
  input ex_pkg::rf_write_t fw_i,
  input ex_pkg::rf_write_t wb_i,
  input logic              ex_valid_i,
  input logic              wb_ready_i,
  input logic              regfile_we_i,
  input logic              lsu_err_i
);

  // Failure counts, summed up by the testbench at the end
  int reset_fails = 0;
  int valid_fails = 0;
  int wb_fails    = 0;

  // First cycle out of reset writes nothing
  a_reset_quiet: assert property (@(posedge clk) $rose(rst_n) |-> !fw_i.we && !wb_i.we)
    else begin
      reset_fails++;
      $error("register file write in the first cycle after reset");
    end

  // Back-pressure from write-back blocks the stage
  a_stall_no_valid: assert property (@(posedge clk) disable iff (!rst_n)
    !wb_ready_i |-> !ex_valid_i)
    else begin
      valid_fails++;
      $error("ex_valid_o high while wb_ready_i is low");
    end

  // Accepted load with a good response writes one cycle later
  a_wb_follows: assert property (@(posedge clk) disable iff (!rst_n)
    ex_valid_i && regfile_we_i && !lsu_err_i |=> wb_i.we)
    else begin
      wb_fails++;
      $error("wb_o.we missing one cycle after a valid write-back op");
    end

endmodule

bind ex_stage ex_stage_checker u_checker (
  .clk          (clk),
  .rst_n        (rst_n),
  .fw_i         (fw_o),
  .wb_i         (wb_o),
  .ex_valid_i   (ex_valid_o),
  .wb_ready_i   (wb_ready_i),
  .regfile_we_i (ex_ctrl_i.regfile_we),
  .lsu_err_i    (lsu_err_i)
);

//--- tb/tb_ex_stage.sv
/*
  Execute stage testbench
*/
`include "ex_settings.svh"

module tb_ex_stage;

  localparam int CLK_PERIOD = 40;
  localparam int TIMEOUT    = 20;
  localparam int XL         = `EX_XLEN;
  localparam int SH         = $clog2(`EX_XLEN);

  logic                             clk;
  logic                             rst_n;
  ex_pkg::alu_req_t [`EX_LANES-1:0] alu_req;
  ex_pkg::mult_req_t                mult_req;
  ex_pkg::ex_ctrl_t                 ctrl;
  logic [XL-1:0]                    csr_rdata;
  logic [XL-1:0]                    lsu_rdata;
  logic                             lsu_ready;
  logic                             lsu_err;
  logic                             wb_ready;
  logic [`EX_CNT_ADDR_W-1:0]        cnt_addr;
  logic                             cnt_we;
  logic [`EX_FCNT_W-1:0]            cnt_wdata;
  ex_pkg::rf_write_t                fw;
  ex_pkg::rf_write_t                wb;
  logic                             branch_decision;
  logic [XL-1:0]                    jump_target;
  logic                             ex_ready;
  logic                             ex_valid;
  logic                             mult_multicycle;
  ex_pkg::tmr_status_t              status;
  logic [`EX_FCNT_W-1:0]            cnt_rdata;

  logic [31:0] rng_state;
  int          errors;
  int          checks;
  int          tests;
  int          test_errors;
  // Expected disagreement count per lane
  int          model_cnt [`EX_LANES];

  ex_stage i_dut (
    .clk               (clk),
    .rst_n             (rst_n),
    .alu_req_i         (alu_req),
    .mult_req_i        (mult_req),
    .ex_ctrl_i         (ctrl),
    .csr_rdata_i       (csr_rdata),
    .lsu_rdata_i       (lsu_rdata),
    .lsu_ready_i       (lsu_ready),
    .lsu_err_i         (lsu_err),
    .wb_ready_i        (wb_ready),
    .cnt_addr_i        (cnt_addr),
    .cnt_we_i          (cnt_we),
    .cnt_wdata_i       (cnt_wdata),
    .fw_o              (fw),
    .wb_o              (wb),
    .branch_decision_o (branch_decision),
    .jump_target_o     (jump_target),
    .ex_ready_o        (ex_ready),
    .ex_valid_o        (ex_valid),
    .mult_multicycle_o (mult_multicycle),
    .tmr_status_o      (status),
    .cnt_rdata_o       (cnt_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Random source and reference models
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift(rng_state);
    return rng_state;
  endfunction

  // Returns {cmp, result}
  function automatic logic [XL:0] alu_model(input ex_pkg::alu_op_e op,
                                            input logic [XL-1:0] a, input logic [XL-1:0] b);
    logic          cmp;
    logic [XL-1:0] res;
    cmp = 1'b0;
    res = '0;
    case (op)
      ex_pkg::ADD:  res = a + b;
      ex_pkg::SUB:  res = a - b;
      ex_pkg::AND:  res = a & b;
      ex_pkg::OR:   res = a | b;
      ex_pkg::XOR:  res = a ^ b;
      ex_pkg::SLL:  res = a << b[SH-1:0];
      ex_pkg::SRL:  res = a >> b[SH-1:0];
      ex_pkg::SRA:  res = $signed(a) >>> b[SH-1:0];
      ex_pkg::SLTU: cmp = (a < b);
      ex_pkg::EQ:   cmp = (a == b);
      ex_pkg::NE:   cmp = (a != b);
      ex_pkg::GE:   cmp = !($signed(a) < $signed(b));
      // SLT and LT
      default:      cmp = ($signed(a) < $signed(b));
    endcase
    if (op >= ex_pkg::SLT) res = {{(XL-1){1'b0}}, cmp};
    return {cmp, res};
  endfunction

  // Full product modulo 2^64, then pick the word
  function automatic logic [XL-1:0] mult_model(input ex_pkg::mult_op_e op,
                                               input logic [XL-1:0] a, input logic [XL-1:0] b);
    logic [2*XL-1:0] a_w;
    logic [2*XL-1:0] b_w;
    logic [2*XL-1:0] prod;
    a_w  = {{XL{a[XL-1] & (op == ex_pkg::MULH || op == ex_pkg::MULHSU)}}, a};
    b_w  = {{XL{b[XL-1] & (op == ex_pkg::MULH)}}, b};
    prod = a_w * b_w;
    return (op == ex_pkg::MUL) ? prod[XL-1:0] : prod[2*XL-1:XL];
  endfunction

  ////////////////////////////////////////////////////////////
  // Driving, sampling and checking
  ////////////////////////////////////////////////////////////

  // Inputs change on the falling edge
  task automatic step();
    @(negedge clk);
  endtask

  // Sample point well away from both edges
  task automatic settle();
    #(CLK_PERIOD/4);
  endtask

  task automatic check_value(input string name, input logic [XL-1:0] got,
                             input logic [XL-1:0] exp);
    checks++;
    if (got !== exp) begin
      $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
      errors++;
      test_errors++;
    end
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("Test %0d %s: %0d errors", tests, name, test_errors);
    test_errors = 0;
  endtask

  task automatic wait_valid(input logic expect_mc, output int cycles);
    cycles = 0;
    while (!ex_valid && cycles < TIMEOUT) begin
      if (expect_mc) check_value("mult_multicycle_o", mult_multicycle, 1);
      step();
      settle();
      cycles++;
    end
    if (!ex_valid) begin
      $display("Timeout: ex_valid_o stayed low for %0d cycles at %0t", TIMEOUT, $time);
      $display("*** FAILED ***");
      $finish;
    end
  endtask

  task automatic random_alu(output ex_pkg::alu_req_t req);
    logic [31:0] r;
    req.operator  = ex_pkg::alu_op_e'(4'(next_rand() % 14));
    req.operand_a = next_rand();
    req.operand_b = next_rand();
    r = next_rand();
    // Equal operands now and then for EQ and GE
    if (r[3:0] == 4'd0) req.operand_b = req.operand_a;
  endtask

  // Same request on every lane
  task automatic drive_alu(input ex_pkg::alu_req_t req);
    ctrl                   = '0;
    ctrl.alu_en            = 1'b1;
    ctrl.regfile_alu_we    = 1'b1;
    ctrl.regfile_alu_waddr = `EX_RADDR_W'(next_rand());
    for (int i = 0; i < `EX_LANES; i++) alu_req[i] = req;
  endtask

  task automatic check_alu(input ex_pkg::alu_req_t req, input logic corr, input logic det);
    logic [XL:0] exp;
    exp = alu_model(req.operator, req.operand_a, req.operand_b);
    settle();
    check_value("fw_o.wdata", fw.wdata, exp[XL-1:0]);
    check_value("branch_decision_o", branch_decision, exp[XL]);
    check_value("tmr_status_o.err_corrected", status.err_corrected, corr);
    check_value("tmr_status_o.err_detected", status.err_detected, det);
  endtask

  task automatic write_count(input int lane, input int value);
    step();
    ctrl      = '0;
    cnt_addr  = `EX_CNT_ADDR_W'(lane);
    cnt_wdata = `EX_FCNT_W'(value);
    cnt_we    = 1'b1;
    step();
    cnt_we         = 1'b0;
    model_cnt[lane] = value;
  endtask

  // Reads every counter with the stage idle
  task automatic check_counts();
    step();
    ctrl = '0;
    settle();
    for (int i = 0; i < `EX_LANES; i++) begin
      cnt_addr = `EX_CNT_ADDR_W'(i);
      #1;
      check_value("cnt_rdata_o", cnt_rdata, model_cnt[i]);
      check_value("tmr_status_o.faulty", status.faulty[i],
                  model_cnt[i] >= `EX_FAULT_THRESHOLD);
    end
  endtask

  // One lane gets a flipped operand bit on an ADD
  task automatic corrupt_add(input int lane, output ex_pkg::alu_req_t req);
    random_alu(req);
    req.operator = ex_pkg::ADD;
    drive_alu(req);
    alu_req[lane].operand_a = req.operand_a ^ (XL'(1) << (next_rand() % XL));
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    ex_pkg::alu_req_t       req;
    logic [XL-1:0]          exp_mul;
    logic [31:0]            r;
    logic [`EX_RADDR_W-1:0] waddr_x;
    logic                   err_exp;
    int                     cycles;
    int                     lane;
    int                     h1;
    int                     assert_fails;

    rng_state   = 32'h1941daef;
    errors      = 0;
    checks      = 0;
    tests       = 0;
    test_errors = 0;
    for (int i = 0; i < `EX_LANES; i++) model_cnt[i] = 0;
    rst_n     = 1'b0;
    alu_req   = '0;
    mult_req  = '0;
    ctrl      = '0;
    csr_rdata = '0;
    lsu_rdata = '0;
    lsu_ready = 1'b1;
    lsu_err   = 1'b0;
    wb_ready  = 1'b1;
    cnt_addr  = '0;
    cnt_we    = 1'b0;
    cnt_wdata = '0;
    repeat (10) step();
    rst_n = 1'b1;

    // Clean random ALU traffic
    for (int n = 0; n < 40; n++) begin
      step();
      random_alu(req);
      drive_alu(req);
      // Branch target passes straight through from decode
      ctrl.jump_target = next_rand();
      check_alu(req, 1'b0, 1'b0);
      check_value("jump_target_o", jump_target, ctrl.jump_target);
    end
    check_counts();
    end_test("identical lanes");

    // Rotate the bad lane so no counter reaches the threshold
    for (int n = 0; n < 6; n++) begin
      step();
      corrupt_add(n % `EX_LANES, req);
      check_alu(req, 1'b1, 1'b0);
      model_cnt[n % `EX_LANES]++;
    end
    check_counts();
    for (int i = 0; i < `EX_LANES; i++) write_count(i, 0);
    end_test("single lane corrected");

    lane = next_rand() % `EX_LANES;
    h1   = (lane == 2) ? 1 : 2;
    for (int n = 0; n < `EX_FAULT_THRESHOLD; n++) begin
      step();
      corrupt_add(lane, req);
      check_alu(req, 1'b1, 1'b0);
      model_cnt[lane]++;
    end
    check_counts();
    // Pair mode keeps the lower healthy lane
    step();
    corrupt_add(h1, req);
    alu_req[lane].operand_b = ~req.operand_b;
    check_alu(req, 1'b0, 1'b1);
    write_count(lane, 0);
    check_counts();
    end_test("faulty lane exclusion");

    for (int n = 0; n < 16; n++) begin
      step();
      ctrl                = '0;
      ctrl.mult_en        = 1'b1;
      ctrl.regfile_alu_we = 1'b1;
      mult_req.operator   = ex_pkg::mult_op_e'(2'(next_rand() % 4));
      mult_req.operand_a  = next_rand();
      mult_req.operand_b  = next_rand();
      exp_mul = mult_model(mult_req.operator, mult_req.operand_a, mult_req.operand_b);
      settle();
      wait_valid(mult_req.operator != ex_pkg::MUL, cycles);
      check_value("ex_valid_o delay", cycles, (mult_req.operator == ex_pkg::MUL) ? 0 : 2);
      check_value("fw_o.wdata", fw.wdata, exp_mul);
      check_value("mult_multicycle_o", mult_multicycle, 0);
    end
    end_test("multiplier");

    for (int n = 0; n < 8; n++) begin
      step();
      r                  = next_rand();
      ctrl               = '0;
      ctrl.lsu_en        = 1'b1;
      ctrl.regfile_we    = 1'b1;
      ctrl.regfile_waddr = `EX_RADDR_W'(r >> 8);
      lsu_err            = r[0];
      waddr_x            = ctrl.regfile_waddr;
      err_exp            = r[0];
      settle();
      wait_valid(1'b0, cycles);
      step();
      ctrl      = '0;
      lsu_err   = 1'b0;
      lsu_rdata = next_rand();
      settle();
      check_value("wb_o.we", wb.we, !err_exp);
      if (!err_exp) begin
        check_value("wb_o.waddr", wb.waddr, waddr_x);
        check_value("wb_o.wdata", wb.wdata, lsu_rdata);
      end
    end
    // CSR data wins over the ALU result
    step();
    random_alu(req);
    drive_alu(req);
    ctrl.csr_access = 1'b1;
    csr_rdata       = next_rand();
    settle();
    check_value("ex_valid_o", ex_valid, 1);
    check_value("fw_o.we", fw.we, 1);
    check_value("fw_o.waddr", fw.waddr, ctrl.regfile_alu_waddr);
    check_value("fw_o.wdata", fw.wdata, csr_rdata);
    end_test("write-back and CSR");

    step();
    ctrl               = '0;
    ctrl.lsu_en        = 1'b1;
    ctrl.regfile_we    = 1'b1;
    ctrl.regfile_waddr = `EX_RADDR_W'(next_rand());
    waddr_x            = ctrl.regfile_waddr;
    settle();
    wait_valid(1'b0, cycles);
    step();
    // Next load waits behind the stall with another address
    ctrl.regfile_waddr = waddr_x ^ 1'b1;
    wb_ready           = 1'b0;
    repeat (4) begin
      settle();
      check_value("ex_valid_o", ex_valid, 0);
      check_value("ex_ready_o", ex_ready, 0);
      check_value("wb_o.we", wb.we, 1);
      check_value("wb_o.waddr", wb.waddr, waddr_x);
      check_value("wb_o.wdata", wb.wdata, lsu_rdata);
      step();
    end
    wb_ready = 1'b1;
    settle();
    wait_valid(1'b0, cycles);
    step();
    ctrl = '0;
    settle();
    check_value("wb_o.we", wb.we, 1);
    check_value("wb_o.waddr", wb.waddr, waddr_x ^ 1'b1);
    end_test("back-pressure");

    step();
    assert_fails = i_dut.u_checker.reset_fails + i_dut.u_checker.valid_fails +
                   i_dut.u_checker.wb_fails;
    $display("Tests %0d, checks %0d, errors %0d, assertion failures %0d",
             tests, checks, errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- all.f
+incdir+include
source/ex_pkg.sv
source/alu_lane.sv
source/tmr_voter.sv
source/fault_counter.sv
source/mult_ctrl.sv
source/mult_datapath.sv
source/ex_stage.sv
tb/ex_stage_checker.sv
tb/tb_ex_stage.sv

//--- Bender.yml
package:
  name: ex_stage

export_include_dirs:
  - include

sources:
  - files:
      - source/ex_pkg.sv
      - source/alu_lane.sv
      - source/tmr_voter.sv
      - source/fault_counter.sv
      - source/mult_ctrl.sv
      - source/mult_datapath.sv
      - source/ex_stage.sv
  - target: test
    files:
      - tb/ex_stage_checker.sv
      - tb/tb_ex_stage.sv
